// File: mem_pkg.sv
// memory subsystem widths, RAM depth and arbiter state encoding
`default_nettype none

package mem_pkg;

  // byte address width seen by both requesters
  localparam int ADDR_W = 32;

  // one RAM word
  localparam int DATA_W = 32;

  // one enable per byte lane
  localparam int BE_W = DATA_W / 8;

  // wait-state count, 0 to 7 extra cycles
  localparam int WAIT_W = 3;

  // RAM depth in words
  localparam int RAM_WORDS = 256;

  // word index width, taken from address bits above the byte offset
  localparam int IDX_W = $clog2(RAM_WORDS);

  // arbiter states
  // data always wins over a fetch raised in the same cycle
  typedef enum logic [1:0] {
    // nothing forwarded to the RAM
    IDLE           = 2'b00,
    // data access owns the RAM
    DATA_REQ       = 2'b01,
    // lone fetch owns the RAM
    INSTR_REQ      = 2'b10,
    // fetch that waited behind a data access
    DATA_INSTR_REQ = 2'b11
  } arb_state_t;

endpackage

`default_nettype wire

// File: ram_if.sv
// ram_if interface for one requester-to-memory link, with cpu and ram modports
`timescale 1ns/1ps
`default_nettype none

interface ram_if import mem_pkg::*; ();

  // request side, held by the requester until busy drops
  logic              ren;
  logic              wen;
  logic [ADDR_W-1:0] addr;
  logic [DATA_W-1:0] wdata;
  logic [BE_W-1:0]   byte_en;

  // response side
  // busy low for exactly the completion cycle
  logic [DATA_W-1:0] rdata;
  logic              busy;

  // requester view
  modport cpu (
    output ren,
    output wen,
    output addr,
    output wdata,
    output byte_en,
    input  rdata,
    input  busy
  );

  // memory view
  modport ram (
    input  ren,
    input  wen,
    input  addr,
    input  wdata,
    input  byte_en,
    output rdata,
    output busy
  );

endinterface

`default_nettype wire

// File: memory_controller.sv
// memory_controller module: data/fetch arbiter FSM with store byte-lane alignment
`timescale 1ns/1ps
`default_nettype none

module memory_controller import mem_pkg::*; (
  input wire CLK,
  input wire nRST,
  ram_if.ram d_ram,
  ram_if.ram i_ram,
  ram_if.cpu out_ram
);

  arb_state_t state_q;
  arb_state_t state_d;

  // request levels from the two ports
  logic d_req;
  logic i_req;

  // RAM completion cycle
  logic ram_done;

  // which port currently owns the RAM
  logic d_sel;
  logic i_sel;

  // store data moved onto its byte lanes
  logic [DATA_W-1:0] wdata_aligned;

  assign d_req    = d_ram.ren | d_ram.wen;
  // fetch port is read only
  assign i_req    = i_ram.ren;
  assign ram_done = ~out_ram.busy;

  // state register
  always_ff @(posedge CLK) begin
    if (!nRST) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // next state
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        // data first, even with a fetch in the same cycle
        if (d_req) begin
          state_d = DATA_REQ;
        end else if (i_req) begin
          state_d = INSTR_REQ;
        end
      end
      DATA_REQ: begin
        // a fetch held behind the data access goes straight to the RAM
        if (ram_done) begin
          state_d = i_req ? DATA_INSTR_REQ : IDLE;
        end
      end
      INSTR_REQ, DATA_INSTR_REQ: begin
        if (ram_done) begin
          state_d = IDLE;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  // port ownership decoded from the registered state
  assign d_sel = (state_q == DATA_REQ);
  assign i_sel = (state_q == INSTR_REQ) || (state_q == DATA_INSTR_REQ);

  // store alignment by byte-enable code
  // the data sits in the low bits and moves up to the enabled lanes
  always_comb begin
    case (d_ram.byte_en)
      // byte in lane 1
      4'h2: begin
        wdata_aligned = d_ram.wdata << 8;
      end
      // byte in lane 2 or upper halfword
      4'h4, 4'hC: begin
        wdata_aligned = d_ram.wdata << 16;
      end
      // byte in lane 3
      4'h8: begin
        wdata_aligned = d_ram.wdata << 24;
      end
      // full word, lane 0 byte, lower halfword
      default: begin
        wdata_aligned = d_ram.wdata;
      end
    endcase
  end

  // request steering toward the RAM
  // nothing reaches the RAM in IDLE
  assign out_ram.ren     = d_sel ? d_ram.ren : (i_sel & i_ram.ren);
  // fetch side never writes
  assign out_ram.wen     = d_sel & d_ram.wen;
  assign out_ram.addr    = d_sel ? d_ram.addr : (i_sel ? i_ram.addr : '0);
  assign out_ram.byte_en = d_sel ? d_ram.byte_en : '0;
  assign out_ram.wdata   = d_sel ? wdata_aligned : '0;

  // busy back to the ports
  // owner mirrors the RAM, the other port stays busy
  assign d_ram.busy = d_sel ? out_ram.busy : 1'b1;
  assign i_ram.busy = i_sel ? out_ram.busy : 1'b1;

  // read data to both ports
  // only the owner sees busy low, so the other ignores it
  assign d_ram.rdata = out_ram.rdata;
  assign i_ram.rdata = out_ram.rdata;

  // never two completions in one cycle
  a_one_port_done: assert property (
    @(posedge CLK) disable iff (!nRST)
    !(!d_ram.busy && !i_ram.busy)
  ) else $error("both ports see busy low in the same cycle");

  // one operation per RAM transaction
  a_no_read_write: assert property (
    @(posedge CLK) disable iff (!nRST)
    !(out_ram.ren && out_ram.wen)
  ) else $error("ren and wen both high toward the RAM");

endmodule

`default_nettype wire

// File: ram_wait_config.sv
// ram_wait_config module: staged wait-state register, committed while the RAM is idle
`timescale 1ns/1ps
`default_nettype none

module ram_wait_config import mem_pkg::*; (
  input  wire              CLK,
  input  wire              nRST,
  input  wire              i_cfg_wen,
  input  wire [WAIT_W-1:0] i_cfg_wait,
  input  wire              i_ram_idle,
  output logic [WAIT_W-1:0] o_wait_cycles
);

  // a count written but not yet applied
  logic              pending_q;
  logic [WAIT_W-1:0] staged_q;

  always_ff @(posedge CLK) begin
    if (!nRST) begin
      pending_q     <= 1'b0;
      staged_q      <= '0;
      o_wait_cycles <= '0;
    end else begin
      // newest write always wins the staging register
      if (i_cfg_wen) begin
        staged_q <= i_cfg_wait;
      end
      if (i_cfg_wen && i_ram_idle) begin
        // idle RAM, apply right away
        o_wait_cycles <= i_cfg_wait;
        pending_q     <= 1'b0;
      end else if (i_cfg_wen) begin
        // transaction running, hold until it ends
        pending_q <= 1'b1;
      end else if (pending_q && i_ram_idle) begin
        // first idle edge after the write
        o_wait_cycles <= staged_q;
        pending_q     <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// File: sram_model.sv
// sram_model module: word RAM with byte-enable writes and programmable busy latency
`timescale 1ns/1ps
`default_nettype none

module sram_model import mem_pkg::*; (
  input  wire              CLK,
  input  wire              nRST,
  ram_if.ram               mem,
  input  wire [WAIT_W-1:0] i_wait_cycles,
  output logic             o_ram_idle
);

  // storage
  logic [DATA_W-1:0] mem_q [RAM_WORDS];

  // read word captured for the completion cycle
  logic [DATA_W-1:0] rdata_q;

  // transaction timing
  // active while counting
  // done for the single completion cycle
  logic              active_q;
  logic              done_q;
  logic [WAIT_W-1:0] cnt_q;

  logic [IDX_W-1:0] word_idx;
  logic             accept;

  // word index from the byte address
  assign word_idx = mem.addr[IDX_W+1:2];

  // no new request is taken during the completion cycle
  assign o_ram_idle = !active_q && !done_q;
  assign accept     = o_ram_idle && (mem.ren || mem.wen);

  // latency counter
  // loaded with W at acceptance and done after W+1 edges
  always_ff @(posedge CLK) begin
    if (!nRST) begin
      active_q <= 1'b0;
      done_q   <= 1'b0;
      cnt_q    <= '0;
    end else begin
      // done lasts one cycle
      done_q <= 1'b0;
      if (accept) begin
        active_q <= 1'b1;
        cnt_q    <= i_wait_cycles;
      end else if (active_q) begin
        if (cnt_q == '0) begin
          active_q <= 1'b0;
          done_q   <= 1'b1;
        end else begin
          cnt_q <= cnt_q - 1'b1;
        end
      end
    end
  end

  // array access
  always_ff @(posedge CLK) begin
    // read lands in rdata_q as the completion cycle starts
    if (active_q && (cnt_q == '0)) begin
      rdata_q <= mem_q[word_idx];
    end
    // write commits lane by lane at the completion edge
    if (done_q && mem.wen) begin
      for (int b = 0; b < BE_W; b++) begin
        if (mem.byte_en[b]) begin
          mem_q[word_idx][8*b +: 8] <= mem.wdata[8*b +: 8];
        end
      end
    end
  end

  assign mem.busy  = ~done_q;
  assign mem.rdata = rdata_q;

  // requester holds its request from acceptance through completion
  a_req_stable: assert property (
    @(posedge CLK) disable iff (!nRST)
    (active_q || done_q) |->
      $stable(mem.ren) && $stable(mem.wen) && $stable(mem.addr) &&
      $stable(mem.byte_en) && (!mem.wen || $stable(mem.wdata))
  ) else $error("request fields changed during a RAM transaction");

  // a completion only lands on a request that is still held
  a_busy_when_idle: assert property (
    @(posedge CLK) disable iff (!nRST)
    !mem.busy |-> (mem.ren || mem.wen)
  ) else $error("busy low while no request is on the link");

endmodule

`default_nettype wire

// File: mem_subsys_top.sv
// mem_subsys_top module: port-to-interface wiring for controller, wait config and RAM
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_top import mem_pkg::*; (
  input  wire              CLK,
  input  wire              nRST,
  // data port
  input  wire              i_d_ren,
  input  wire              i_d_wen,
  input  wire [ADDR_W-1:0] i_d_addr,
  input  wire [DATA_W-1:0] i_d_wdata,
  input  wire [BE_W-1:0]   i_d_byte_en,
  output logic [DATA_W-1:0] o_d_rdata,
  output logic             o_d_busy,
  // instruction port
  input  wire              i_i_ren,
  input  wire [ADDR_W-1:0] i_i_addr,
  output logic [DATA_W-1:0] o_i_rdata,
  output logic             o_i_busy,
  // wait-state configuration
  input  wire              i_cfg_wen,
  input  wire [WAIT_W-1:0] i_cfg_wait
);

  // links: data port, fetch port, controller to RAM
  ram_if d_link ();
  ram_if i_link ();
  ram_if mem_link ();

  // committed latency and RAM idle status
  logic [WAIT_W-1:0] wait_cycles;
  logic              ram_idle;

  // data port onto its link
  assign d_link.ren     = i_d_ren;
  assign d_link.wen     = i_d_wen;
  assign d_link.addr    = i_d_addr;
  assign d_link.wdata   = i_d_wdata;
  assign d_link.byte_en = i_d_byte_en;
  assign o_d_rdata      = d_link.rdata;
  assign o_d_busy       = d_link.busy;

  // fetch port, write side tied off
  assign i_link.ren     = i_i_ren;
  assign i_link.wen     = 1'b0;
  assign i_link.addr    = i_i_addr;
  assign i_link.wdata   = '0;
  assign i_link.byte_en = '0;
  assign o_i_rdata      = i_link.rdata;
  assign o_i_busy       = i_link.busy;

  memory_controller ctrl_i (
    .CLK     (CLK),
    .nRST    (nRST),
    .d_ram   (d_link.ram),
    .i_ram   (i_link.ram),
    .out_ram (mem_link.cpu)
  );

  ram_wait_config cfg_i (
    .CLK           (CLK),
    .nRST          (nRST),
    .i_cfg_wen     (i_cfg_wen),
    .i_cfg_wait    (i_cfg_wait),
    .i_ram_idle    (ram_idle),
    .o_wait_cycles (wait_cycles)
  );

  sram_model ram_i (
    .CLK           (CLK),
    .nRST          (nRST),
    .mem           (mem_link.ram),
    .i_wait_cycles (wait_cycles),
    .o_ram_idle    (ram_idle)
  );

endmodule

`default_nettype wire

// File: tb_vectors.svh
// operation codes, table entry layout and the stimulus table of the memory testbench
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// kinds of table entry
typedef enum logic [2:0] {
  OP_CFG,
  OP_DRD,
  OP_DWR,
  OP_FETCH,
  OP_BOTH,
  OP_DRD_CFG
} op_t;

// one operation with its expected latencies
// lat counts edges from the sampling edge to the completion cycle
// lat2 counts from the data completion to the fetch completion
typedef struct packed {
  op_t         op;
  logic [31:0] addr;
  logic [31:0] addr2;
  logic [3:0]  be;
  logic [2:0]  cfg;
  logic [7:0]  lat;
  logic [7:0]  lat2;
} vec_t;

localparam int NUM_VEC = 30;

vec_t vectors [NUM_VEC];

// columns: op, data or fetch address, fetch address of OP_BOTH, byte enables,
// wait count, latency W+2, fetch latency W+3 after the data completion
task automatic load_vectors();
  vectors[0]  = '{OP_CFG,     32'h000, 32'h000, 4'h0, 3'd0, 8'd0, 8'd0};
  vectors[1]  = '{OP_DWR,     32'h000, 32'h000, 4'hF, 3'd0, 8'd2, 8'd0};
  vectors[2]  = '{OP_DWR,     32'h004, 32'h000, 4'hF, 3'd0, 8'd2, 8'd0};
  vectors[3]  = '{OP_DWR,     32'h3FC, 32'h000, 4'hF, 3'd0, 8'd2, 8'd0};
  vectors[4]  = '{OP_DRD,     32'h000, 32'h000, 4'hF, 3'd0, 8'd2, 8'd0};
  vectors[5]  = '{OP_DRD,     32'h004, 32'h000, 4'hF, 3'd0, 8'd2, 8'd0};
  vectors[6]  = '{OP_DRD,     32'h3FC, 32'h000, 4'hF, 3'd0, 8'd2, 8'd0};
  vectors[7]  = '{OP_FETCH,   32'h000, 32'h000, 4'h0, 3'd0, 8'd2, 8'd0};
  vectors[8]  = '{OP_FETCH,   32'h3FC, 32'h000, 4'h0, 3'd0, 8'd2, 8'd0};
  // three wait states, byte and halfword lanes
  vectors[9]  = '{OP_CFG,     32'h000, 32'h000, 4'h0, 3'd3, 8'd0, 8'd0};
  vectors[10] = '{OP_DWR,     32'h010, 32'h000, 4'hF, 3'd0, 8'd5, 8'd0};
  vectors[11] = '{OP_DWR,     32'h010, 32'h000, 4'h1, 3'd0, 8'd5, 8'd0};
  vectors[12] = '{OP_DWR,     32'h010, 32'h000, 4'h2, 3'd0, 8'd5, 8'd0};
  vectors[13] = '{OP_DWR,     32'h010, 32'h000, 4'h4, 3'd0, 8'd5, 8'd0};
  vectors[14] = '{OP_DWR,     32'h010, 32'h000, 4'h8, 3'd0, 8'd5, 8'd0};
  vectors[15] = '{OP_DRD,     32'h010, 32'h000, 4'hF, 3'd0, 8'd5, 8'd0};
  vectors[16] = '{OP_DWR,     32'h020, 32'h000, 4'hF, 3'd0, 8'd5, 8'd0};
  vectors[17] = '{OP_DWR,     32'h020, 32'h000, 4'h3, 3'd0, 8'd5, 8'd0};
  vectors[18] = '{OP_DWR,     32'h020, 32'h000, 4'hC, 3'd0, 8'd5, 8'd0};
  vectors[19] = '{OP_DRD,     32'h020, 32'h000, 4'hF, 3'd0, 8'd5, 8'd0};
  vectors[20] = '{OP_FETCH,   32'h020, 32'h000, 4'h0, 3'd0, 8'd5, 8'd0};
  // seven wait states, contention and a cfg write under a running access
  vectors[21] = '{OP_CFG,     32'h000, 32'h000, 4'h0, 3'd7, 8'd0, 8'd0};
  vectors[22] = '{OP_BOTH,    32'h004, 32'h010, 4'hF, 3'd0, 8'd9, 8'd10};
  vectors[23] = '{OP_DWR,     32'h008, 32'h000, 4'hF, 3'd0, 8'd9, 8'd0};
  vectors[24] = '{OP_DRD,     32'h008, 32'h000, 4'hF, 3'd0, 8'd9, 8'd0};
  vectors[25] = '{OP_DRD_CFG, 32'h008, 32'h000, 4'hF, 3'd0, 8'd9, 8'd0};
  vectors[26] = '{OP_DRD,     32'h004, 32'h000, 4'hF, 3'd0, 8'd2, 8'd0};
  vectors[27] = '{OP_BOTH,    32'h020, 32'h3FC, 4'hF, 3'd0, 8'd2, 8'd3};
  vectors[28] = '{OP_CFG,     32'h000, 32'h000, 4'h0, 3'd3, 8'd0, 8'd0};
  vectors[29] = '{OP_BOTH,    32'h3FC, 32'h008, 4'hF, 3'd0, 8'd5, 8'd6};
endtask

`endif

// File: tb_mem_subsys.sv
// tb_mem_subsys module: clock, reset, table-driven access loop, checks and timeout
`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsys import mem_pkg::*; ();

  localparam int          RST_CYCLES = 4;
  localparam logic [31:0] SEED       = 32'ha743_3e1c;

  logic              CLK;
  logic              nRST;
  logic              i_d_ren;
  logic              i_d_wen;
  logic [ADDR_W-1:0] i_d_addr;
  logic [DATA_W-1:0] i_d_wdata;
  logic [BE_W-1:0]   i_d_byte_en;
  logic [DATA_W-1:0] o_d_rdata;
  logic              o_d_busy;
  logic              i_i_ren;
  logic [ADDR_W-1:0] i_i_addr;
  logic [DATA_W-1:0] o_i_rdata;
  logic              o_i_busy;
  logic              i_cfg_wen;
  logic [WAIT_W-1:0] i_cfg_wait;

  // expected RAM contents
  logic [DATA_W-1:0] shadow [RAM_WORDS];
  int                cycle_cnt;

  `include "tb_vectors.svh"

  // worst case per entry plus reset
  localparam int TIMEOUT_CYCLES = NUM_VEC * (2 * 7 + 4) + RST_CYCLES;

  mem_subsys_top dut_i (
    .CLK         (CLK),
    .nRST        (nRST),
    .i_d_ren     (i_d_ren),
    .i_d_wen     (i_d_wen),
    .i_d_addr    (i_d_addr),
    .i_d_wdata   (i_d_wdata),
    .i_d_byte_en (i_d_byte_en),
    .o_d_rdata   (o_d_rdata),
    .o_d_busy    (o_d_busy),
    .i_i_ren     (i_i_ren),
    .i_i_addr    (i_i_addr),
    .o_i_rdata   (o_i_rdata),
    .o_i_busy    (o_i_busy),
    .i_cfg_wen   (i_cfg_wen),
    .i_cfg_wait  (i_cfg_wait)
  );

  // 20 ns clock
  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;
  end

  always @(posedge CLK) begin
    cycle_cnt++;
    if (cycle_cnt > TIMEOUT_CYCLES) begin
      $display("timeout: no end of test after %0d clock cycles", TIMEOUT_CYCLES);
      $display("Test FAILED");
      $fatal(1, "run stopped by the cycle limit");
    end
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("MISMATCH %s got 0x%08h expected 0x%08h", name, got, exp);
      $display("Test FAILED");
      $fatal(1, "first error");
    end
  endtask

  // word after a store
  // data sits low and moves up to the lowest enabled lane
  function automatic logic [DATA_W-1:0] merge_store(input logic [DATA_W-1:0] old_word,
                                                    input logic [DATA_W-1:0] data,
                                                    input logic [BE_W-1:0]   be);
    logic [DATA_W-1:0] lanes;
    logic [DATA_W-1:0] word;
    int                low;
    low = 0;
    for (int b = BE_W - 1; b >= 0; b--) begin
      if (be[b]) begin
        low = b;
      end
    end
    lanes = data << (8 * low);
    word  = old_word;
    for (int b = 0; b < BE_W; b++) begin
      if (be[b]) begin
        word[8*b +: 8] = lanes[8*b +: 8];
      end
    end
    return word;
  endfunction

  // one-cycle pulse that commits at once on an idle RAM
  task automatic cfg_write(input vec_t v);
    @(posedge CLK);
    i_cfg_wen  <= 1'b1;
    i_cfg_wait <= v.cfg;
    @(posedge CLK);
    i_cfg_wen  <= 1'b0;
  endtask

  // lone data read, data write or fetch
  task automatic single_access(input vec_t v);
    logic [DATA_W-1:0] data;
    logic [DATA_W-1:0] rdata;
    logic              is_fetch;
    logic              done;
    int                n;
    data     = $urandom();
    is_fetch = (v.op == OP_FETCH);
    done     = 1'b0;
    rdata    = '0;
    n        = 0;
    @(posedge CLK);
    if (is_fetch) begin
      i_i_ren  <= 1'b1;
      i_i_addr <= v.addr;
    end else begin
      i_d_ren     <= (v.op != OP_DWR);
      i_d_wen     <= (v.op == OP_DWR);
      i_d_addr    <= v.addr;
      i_d_wdata   <= data;
      i_d_byte_en <= v.be;
    end
    while (!done) begin
      @(negedge CLK);
      n++;
      // the port not served stays busy
      if (is_fetch) begin
        check_value("o_d_busy", 32'(o_d_busy), 32'd1);
        done  = !o_i_busy;
        rdata = o_i_rdata;
      end else begin
        check_value("o_i_busy", 32'(o_i_busy), 32'd1);
        done  = !o_d_busy;
        rdata = o_d_rdata;
      end
      @(posedge CLK);
      // new count written while the RAM is counting
      if ((v.op == OP_DRD_CFG) && (n == 2)) begin
        i_cfg_wen  <= 1'b1;
        i_cfg_wait <= v.cfg;
      end else begin
        i_cfg_wen <= 1'b0;
      end
    end
    i_d_ren <= 1'b0;
    i_d_wen <= 1'b0;
    i_i_ren <= 1'b0;
    // first negedge falls before the request is sampled
    check_value(is_fetch ? "o_i_busy latency" : "o_d_busy latency",
                32'(n - 2), 32'(v.lat));
    if (v.op == OP_DWR) begin
      shadow[v.addr[9:2]] = merge_store(shadow[v.addr[9:2]], data, v.be);
    end else begin
      check_value(is_fetch ? "o_i_rdata" : "o_d_rdata", rdata, shadow[v.addr[9:2]]);
    end
  endtask

  // data read and fetch raised in the same cycle
  task automatic dual_access(input vec_t v);
    logic [DATA_W-1:0] d_rdata;
    logic [DATA_W-1:0] i_rdata;
    int                n;
    int                d_done_at;
    int                i_done_at;
    d_rdata   = '0;
    i_rdata   = '0;
    n         = 0;
    d_done_at = 0;
    i_done_at = 0;
    @(posedge CLK);
    i_d_ren  <= 1'b1;
    i_d_addr <= v.addr;
    i_i_ren  <= 1'b1;
    i_i_addr <= v.addr2;
    while (i_done_at == 0) begin
      @(negedge CLK);
      n++;
      check_value("o_d_busy|o_i_busy", 32'(o_d_busy | o_i_busy), 32'd1);
      if (!o_d_busy) begin
        d_done_at = n;
        d_rdata   = o_d_rdata;
      end
      if (!o_i_busy) begin
        i_done_at = n;
        i_rdata   = o_i_rdata;
      end
      @(posedge CLK);
      if (d_done_at == n) begin
        i_d_ren <= 1'b0;
      end
    end
    i_i_ren <= 1'b0;
    // first negedge falls before the requests are sampled
    check_value("o_d_busy latency", 32'(d_done_at - 2), 32'(v.lat));
    check_value("o_i_busy latency", 32'(i_done_at - d_done_at), 32'(v.lat2));
    check_value("o_d_rdata", d_rdata, shadow[v.addr[9:2]]);
    check_value("o_i_rdata", i_rdata, shadow[v.addr2[9:2]]);
  endtask

  initial begin
    nRST        = 1'b0;
    i_d_ren     = 1'b0;
    i_d_wen     = 1'b0;
    i_d_addr    = '0;
    i_d_wdata   = '0;
    i_d_byte_en = '0;
    i_i_ren     = 1'b0;
    i_i_addr    = '0;
    i_cfg_wen   = 1'b0;
    i_cfg_wait  = '0;
    cycle_cnt   = 0;
    void'($urandom(SEED));
    load_vectors();
    repeat (RST_CYCLES) @(posedge CLK);
    nRST <= 1'b1;
    // both ports busy while nothing is requested
    repeat (4) begin
      @(negedge CLK);
      check_value("o_d_busy", 32'(o_d_busy), 32'd1);
      check_value("o_i_busy", 32'(o_i_busy), 32'd1);
    end
    for (int k = 0; k < NUM_VEC; k++) begin
      case (vectors[k].op)
        OP_CFG:  cfg_write(vectors[k]);
        OP_BOTH: dual_access(vectors[k]);
        default: single_access(vectors[k]);
      endcase
    end
    $display("Test OK");
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
+incdir+.
mem_pkg.sv
ram_if.sv
memory_controller.sv
ram_wait_config.sv
sram_model.sv
mem_subsys_top.sv
tb_mem_subsys.sv

// File: run_sim.sh
#!/bin/sh
# build and run the memory subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_mem_subsys -Mdir obj_dir -f list.f

# the log decides the result
./obj_dir/Vtb_mem_subsys 2>&1 | tee sim.log

if grep -q "Test FAILED" sim.log; then
  echo "simulation failed"
  exit 1
fi
echo "simulation passed"
